// ==== rv32ExecCore.f ====
src/rvExecPkg.sv
src/regFile.sv
src/aluUnit.sv
src/instrFieldSplit.sv
src/opDecode.sv
src/resultStage.sv
src/rvExecTop.sv
dv/rvExecTb.sv

// ==== Bender.yml ====
package:
  name: rv32ExecCore

sources:
  - src/rvExecPkg.sv
  - src/regFile.sv
  - src/aluUnit.sv
  - src/instrFieldSplit.sv
  - src/opDecode.sv
  - src/resultStage.sv
  - src/rvExecTop.sv
  - target: test
    files:
      - dv/rvExecTb.sv

// ==== dv/rvExecTb.sv ====
`timescale 1ns/1ps

module rvExecTb;

	localparam logic [6:0] opcReg    = 7'b0110011;
	localparam logic [6:0] opcImm    = 7'b0010011;
	localparam logic [6:0] opcLoad   = 7'b0000011;
	localparam logic [6:0] opcStore  = 7'b0100011;
	localparam logic [6:0] opcBranch = 7'b1100011;
	localparam logic [6:0] opcJal    = 7'b1101111;
	localparam logic [6:0] opcJalr   = 7'b1100111;
	localparam logic [6:0] opcLui    = 7'b0110111;
	localparam logic [6:0] opcAuipc  = 7'b0010111;
	localparam int drainLimit = 20; // cycles to wait for outstanding results

	typedef struct packed {
		logic        rdWrite;
		logic [4:0]  rdNum;
		logic [31:0] rdData;
		logic        taken;
		logic [31:0] nextPc;
		logic        memRead;
		logic        memWrite;
		logic [31:0] memAddr;
		logic [31:0] storeData;
		logic        illegal;
	} outcomeT;

	logic        clk = 1'b0;
	logic        arstN;
	logic        instrValid;
	logic [31:0] instrBits;
	logic [31:0] pcIn;
	logic        resultValid;
	logic        rdWrite;
	logic [4:0]  rdNum;
	logic [31:0] rdData;
	logic        branchTaken;
	logic [31:0] nextPc;
	logic        memRead;
	logic        memWrite;
	logic [31:0] memAddr;
	logic [31:0] storeData;
	logic        illegalInstr;

	logic [31:0] shadow [32]; // reference register file
	logic [31:0] pcCur;
	outcomeT     expQ [$];
	outcomeT     expCur = '0; // expectation for the result now on the outputs
	int          errorCount = 0;
	int          errorsAtStart = 0;
	int          testsPassed = 0;
	int          testsFailed = 0;
	int          branchKinds [6] = '{0, 1, 4, 5, 6, 7};

	rvExecTop #(
		.numRegs(32)
	) rvExecTop_inst (
		.clk,
		.arstN,
		.instrValid,
		.instr(instrBits),
		.pc(pcIn),
		.resultValid,
		.rdWrite,
		.rdNum,
		.rdData,
		.branchTaken,
		.nextPc,
		.memRead,
		.memWrite,
		.memAddr,
		.storeData,
		.illegalInstr
	);

	always #20 clk = ~clk;

	task automatic reportError(input string msg);
		errorCount++;
		$display("** Error at %0t: %s", $time, msg);
	endtask

	// result is high for one cycle, take its expectation mid-cycle
	always @(negedge clk)
	begin
		if (resultValid)
		begin
			if (expQ.size() == 0)
				reportError("result arrived with no instruction outstanding");
			else
				expCur = expQ.pop_front();
		end
	end

	latencyExact: assert property (@(posedge clk) disable iff (!arstN)
		instrValid |-> ##3 resultValid)
		else reportError("resultValid did not follow instrValid after 3 cycles");
	noStrayResult: assert property (@(posedge clk) disable iff (!arstN)
		resultValid |-> $past(instrValid, 3))
		else reportError("resultValid without instrValid 3 cycles earlier");
	idleQuiet: assert property (@(posedge clk) disable iff (!arstN)
		!resultValid |-> !rdWrite && !memRead && !memWrite && !branchTaken && !illegalInstr)
		else reportError("strobe high while resultValid is low");
	writeFlag: assert property (@(posedge clk) disable iff (!arstN)
		resultValid |-> rdWrite == expCur.rdWrite)
		else reportError($sformatf("rdWrite %b, expected %b", $sampled(rdWrite),
			$sampled(expCur.rdWrite)));
	writeValue: assert property (@(posedge clk) disable iff (!arstN)
		resultValid && expCur.rdWrite |-> rdNum == expCur.rdNum && rdData == expCur.rdData)
		else reportError($sformatf("x%0d = %h, expected x%0d = %h", $sampled(rdNum),
			$sampled(rdData), $sampled(expCur.rdNum), $sampled(expCur.rdData)));
	branchMatch: assert property (@(posedge clk) disable iff (!arstN)
		resultValid |-> branchTaken == expCur.taken)
		else reportError($sformatf("branchTaken %b, expected %b", $sampled(branchTaken),
			$sampled(expCur.taken)));
	nextPcMatch: assert property (@(posedge clk) disable iff (!arstN)
		resultValid && !expCur.illegal |-> nextPc == expCur.nextPc)
		else reportError($sformatf("nextPc %h, expected %h", $sampled(nextPc),
			$sampled(expCur.nextPc)));
	memStrobes: assert property (@(posedge clk) disable iff (!arstN)
		resultValid |-> memRead == expCur.memRead && memWrite == expCur.memWrite)
		else reportError($sformatf("memRead/memWrite %b%b, expected %b%b", $sampled(memRead),
			$sampled(memWrite), $sampled(expCur.memRead), $sampled(expCur.memWrite)));
	memAddrMatch: assert property (@(posedge clk) disable iff (!arstN)
		resultValid && (expCur.memRead || expCur.memWrite) |-> memAddr == expCur.memAddr)
		else reportError($sformatf("memAddr %h, expected %h", $sampled(memAddr),
			$sampled(expCur.memAddr)));
	storeDataMatch: assert property (@(posedge clk) disable iff (!arstN)
		resultValid && expCur.memWrite |-> storeData == expCur.storeData)
		else reportError($sformatf("storeData %h, expected %h", $sampled(storeData),
			$sampled(expCur.storeData)));
	illegalMatch: assert property (@(posedge clk) disable iff (!arstN)
		resultValid |-> illegalInstr == expCur.illegal)
		else reportError($sformatf("illegalInstr %b, expected %b", $sampled(illegalInstr),
			$sampled(expCur.illegal)));

	// RV32I integer ops, alt is instr bit 30
	function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5:
			begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic refBranch(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic outcomeT baseOutcome();
		outcomeT e;
		e = '0;
		e.nextPc = pcCur + 32'd4; // sequential unless told otherwise
		return e;
	endfunction

	function automatic void setReg(input logic [4:0] rd, input logic [31:0] val);
		if (rd != 5'd0)
			shadow[rd] = val;
	endfunction

	function automatic logic [4:0] pickReg();
		return 5'($urandom_range(31, 1));
	endfunction

	// one instruction, then two idle cycles before the next may issue
	task automatic issueInstr(input logic [31:0] word, input outcomeT e);
		expQ.push_back(e);
		instrValid = 1'b1;
		instrBits  = word;
		pcIn       = pcCur;
		@(posedge clk);
		#2;
		instrValid = 1'b0;
		instrBits  = $urandom(); // junk while not valid
		pcCur      = pcCur + 32'd4;
		repeat (2)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic aluR(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		outcomeT e;
		e = baseOutcome();
		e.rdWrite = (rd != 5'd0);
		e.rdNum   = rd;
		e.rdData  = refAlu(f3, alt, shadow[rs1], shadow[rs2]);
		setReg(rd, e.rdData);
		issueInstr({1'b0, alt, 5'b0, rs2, rs1, f3, rd, opcReg}, e);
	endtask

	task automatic aluI(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm12);
		outcomeT     e;
		logic [11:0] immBits;
		immBits = (f3 == 3'd1 || f3 == 3'd5) ? {1'b0, alt, 5'b0, imm12[4:0]} : imm12;
		e = baseOutcome();
		e.rdWrite = (rd != 5'd0);
		e.rdNum   = rd;
		e.rdData  = refAlu(f3, f3 == 3'd5 && alt, shadow[rs1], {{20{immBits[11]}}, immBits});
		setReg(rd, e.rdData);
		issueInstr({immBits, rs1, f3, rd, opcImm}, e);
	endtask

	task automatic upperImm(input logic [6:0] opc, input logic [4:0] rd,
		input logic [19:0] imm20);
		outcomeT e;
		e = baseOutcome();
		e.rdWrite = (rd != 5'd0);
		e.rdNum   = rd;
		e.rdData  = (opc == opcAuipc) ? pcCur + {imm20, 12'b0} : {imm20, 12'b0};
		setReg(rd, e.rdData);
		issueInstr({imm20, rd, opc}, e);
	endtask

	task automatic jumpLink(input logic [4:0] rd, input logic [20:0] off);
		outcomeT e;
		e = baseOutcome();
		e.rdWrite = (rd != 5'd0);
		e.rdNum   = rd;
		e.rdData  = pcCur + 32'd4;
		e.nextPc  = pcCur + {{11{off[20]}}, off};
		setReg(rd, e.rdData);
		issueInstr({off[20], off[10:1], off[11], off[19:12], rd, opcJal}, e);
	endtask

	task automatic jumpReg(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm12);
		outcomeT e;
		e = baseOutcome();
		e.rdWrite = (rd != 5'd0);
		e.rdNum   = rd;
		e.rdData  = pcCur + 32'd4;
		e.nextPc  = (shadow[rs1] + {{20{imm12[11]}}, imm12}) & ~32'd1; // target before link
		setReg(rd, e.rdData);
		issueInstr({imm12, rs1, 3'd0, rd, opcJalr}, e);
	endtask

	task automatic branchOp(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [12:0] off);
		outcomeT e;
		e = baseOutcome();
		e.taken = refBranch(f3, shadow[rs1], shadow[rs2]);
		if (e.taken)
			e.nextPc = pcCur + {{19{off[12]}}, off};
		issueInstr({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opcBranch}, e);
	endtask

	task automatic memOp(input logic isStore, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [11:0] imm12);
		outcomeT e;
		e = baseOutcome();
		e.memRead   = !isStore;
		e.memWrite  = isStore;
		e.memAddr   = shadow[rs1] + {{20{imm12[11]}}, imm12};
		e.storeData = shadow[rs2];
		if (isStore)
			issueInstr({imm12[11:5], rs2, rs1, 3'd2, imm12[4:0], opcStore}, e);
		else
			issueInstr({imm12, rs1, 3'd2, rd, opcLoad}, e);
	endtask

	task automatic unknownOp(input logic [31:0] word);
		outcomeT e;
		e = baseOutcome();
		e.illegal = 1'b1; // no write, no strobe
		issueInstr(word, e);
	endtask

	task automatic finishTest(input int num, input string name);
		int   waited;
		logic ok;
		waited = 0;
		while (expQ.size() != 0 && waited < drainLimit)
		begin
			@(posedge clk);
			#2;
			waited++;
		end
		ok = (expQ.size() == 0) && (errorCount == errorsAtStart);
		if (expQ.size() != 0)
		begin
			$display("Timeout: %0d results never arrived in check %0d", expQ.size(), num);
			expQ.delete();
		end
		if (ok)
			testsPassed++;
		else
			testsFailed++;
		$display("check %0d %s: %s", num, name, ok ? "ok" : "FAIL");
		errorsAtStart = errorCount;
	endtask

	initial
	begin
		void'($urandom(32'hd85cf2c9));
		arstN      = 1'b0;
		instrValid = 1'b0;
		instrBits  = '0;
		pcIn       = '0;
		pcCur      = 32'h0000_1000;
		shadow     = '{default: '0};
		repeat (4) @(posedge clk);
		#2;
		arstN = 1'b1;

		repeat (8)
		begin
			@(posedge clk);
			#2;
		end
		finishTest(1, "quiet after reset");

		for (int r = 1; r < 32; r++)
		begin
			upperImm(opcLui, 5'(r), 20'($urandom()));
			aluI(3'd0, 1'b0, 5'(r), 5'(r), 12'($urandom())); // fill low bits
		end
		for (int f = 0; f < 8; f++)
		begin
			aluR(3'(f), 1'b0, pickReg(), pickReg(), pickReg());
			aluI(3'(f), 1'b0, pickReg(), pickReg(), 12'($urandom()));
			if (f == 0 || f == 5)
				aluR(3'(f), 1'b1, pickReg(), pickReg(), pickReg()); // sub, sra
			if (f == 5)
				aluI(3'(f), 1'b1, pickReg(), pickReg(), 12'($urandom())); // srai
		end
		repeat (24)
			aluR(3'($urandom_range(7, 0)), 1'b0, pickReg(), pickReg(), pickReg());
		aluR(3'd0, 1'b0, 5'd0, 5'd1, 5'd2); // x0 target
		finishTest(2, "alu ops");

		upperImm(opcLui, 5'd20, 20'($urandom()));
		aluI(3'd0, 1'b0, 5'd21, 5'd20, 12'd0);
		aluI(3'd0, 1'b0, 5'd22, 5'd0, 12'd5);
		aluI(3'd0, 1'b0, 5'd23, 5'd0, 12'hffd); // -3, unsigned large
		foreach (branchKinds[k])
		begin
			branchOp(3'(branchKinds[k]), 5'd20, 5'd21, 13'($urandom()) & ~13'd1);
			branchOp(3'(branchKinds[k]), 5'd22, 5'd23, 13'($urandom()) & ~13'd1);
			branchOp(3'(branchKinds[k]), 5'd23, 5'd22, 13'($urandom()) & ~13'd1);
		end
		finishTest(3, "branches");

		jumpLink(5'd1, 21'($urandom()) & ~21'd1);
		jumpLink(5'd0, 21'($urandom()) & ~21'd1);
		aluI(3'd0, 1'b0, 5'd24, 5'd0, 12'd5);
		jumpReg(5'd25, 5'd24, 12'd2); // odd target 7
		jumpReg(5'd24, 5'd24, 12'hff8); // rd same as rs1
		repeat (3)
			upperImm(opcAuipc, pickReg(), 20'($urandom()));
		finishTest(4, "jumps and auipc");

		repeat (8)
		begin
			memOp(1'b0, pickReg(), pickReg(), pickReg(), 12'($urandom()));
			memOp(1'b1, pickReg(), pickReg(), pickReg(), 12'($urandom()));
		end
		finishTest(5, "loads and stores");

		aluI(3'd0, 1'b0, 5'd5, 5'd0, 12'h123);
		unknownOp({20'($urandom()), 5'd5, 7'b1111111});
		unknownOp({20'($urandom()), 5'd5, 7'b1110011});
		unknownOp({20'($urandom()), 5'd5, 7'b0000000});
		aluI(3'd0, 1'b0, 5'd6, 5'd5, 12'd0); // x5 must be untouched
		finishTest(6, "unknown opcodes");

		$display("checks passed %0d, failed %0d, errors %0d", testsPassed, testsFailed,
			errorCount);
		if (testsFailed == 0 && errorCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== src/rvExecTop.sv ====
`timescale 1ns/1ps

module rvExecTop #(
	parameter int numRegs = 32
) (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic                       instrValid,
	input  rvExecPkg::instrWord        instr,
	input  logic [rvExecPkg::XLEN-1:0] pc,
	output logic                       resultValid,
	output logic                       rdWrite,
	output logic [4:0]                 rdNum,
	output logic [rvExecPkg::XLEN-1:0] rdData,
	output logic                       branchTaken,
	output logic [rvExecPkg::XLEN-1:0] nextPc,
	output logic                       memRead,
	output logic                       memWrite,
	output logic [rvExecPkg::XLEN-1:0] memAddr,
	output logic [rvExecPkg::XLEN-1:0] storeData,
	output logic                       illegalInstr
);
	import rvExecPkg::*;

	// split stage outputs
	logic            fieldsValid;
	logic [6:0]      opcode;
	logic [2:0]      func3;
	logic            func7Bit5;
	logic            shiftArith;
	logic [4:0]      rs1Num;
	logic [4:0]      rs2Num;
	logic [4:0]      rdNumF;
	logic [XLEN-1:0] immValue;
	logic [XLEN-1:0] pcValue;

	// execute stage outputs
	logic               exValid;
	logic [XLEN-1:0]    aluResult;
	logic [CLASS_W-1:0] instrClass;
	logic [4:0]         exRd;
	logic [XLEN-1:0]    exPc;
	logic [XLEN-1:0]    exImm;
	logic [XLEN-1:0]    exStoreData;
	logic               illegal;

	// writeback loop
	logic            wbWrite;
	logic [4:0]      wbNum;
	logic [XLEN-1:0] wbData;

	instrFieldSplit instrFieldSplit_inst (
		.clk,
		.arstN,
		.instrValid,
		.instr,
		.pc,
		.fieldsValid,
		.opcode,
		.func3,
		.func7Bit5,
		.shiftArith,
		.rs1Num,
		.rs2Num,
		.rdNum(rdNumF),
		.immValue,
		.pcValue
	);

	opDecode #(
		.numRegs(numRegs)
	) opDecode_inst (
		.clk,
		.arstN,
		.fieldsValid,
		.opcode,
		.func3,
		.func7Bit5,
		.shiftArith,
		.rs1Num,
		.rs2Num,
		.rdNum(rdNumF),
		.immValue,
		.pcValue,
		.wbWrite,
		.wbNum,
		.wbData,
		.exValid,
		.aluResult,
		.instrClass,
		.exRd,
		.exPc,
		.exImm,
		.exStoreData,
		.illegal
	);

	resultStage resultStage_inst (
		.clk,
		.arstN,
		.exValid,
		.aluResult,
		.instrClass,
		.exRd,
		.exPc,
		.exImm,
		.exStoreData,
		.illegal,
		.resultValid,
		.rdWrite,
		.rdNum,
		.rdData,
		.branchTaken,
		.nextPc,
		.memRead,
		.memWrite,
		.memAddr,
		.storeData,
		.illegalInstr,
		.wbWrite,
		.wbNum,
		.wbData
	);

endmodule

// ==== src/resultStage.sv ====
`timescale 1ns/1ps

module resultStage (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          exValid,
	input  logic [rvExecPkg::XLEN-1:0]    aluResult,
	input  logic [rvExecPkg::CLASS_W-1:0] instrClass,
	input  logic [4:0]                    exRd,
	input  logic [rvExecPkg::XLEN-1:0]    exPc,
	input  logic [rvExecPkg::XLEN-1:0]    exImm,
	input  logic [rvExecPkg::XLEN-1:0]    exStoreData,
	input  logic                          illegal,
	output logic                          resultValid,
	output logic                          rdWrite,
	output logic [4:0]                    rdNum,
	output logic [rvExecPkg::XLEN-1:0]    rdData,
	output logic                          branchTaken,
	output logic [rvExecPkg::XLEN-1:0]    nextPc,
	output logic                          memRead,
	output logic                          memWrite,
	output logic [rvExecPkg::XLEN-1:0]    memAddr,
	output logic [rvExecPkg::XLEN-1:0]    storeData,
	output logic                          illegalInstr,
	output logic                          wbWrite,
	output logic [4:0]                    wbNum,
	output logic [rvExecPkg::XLEN-1:0]    wbData
);
	import rvExecPkg::*;

	logic            live;
	logic [XLEN-1:0] pcPlus4;
	logic            writeNext;
	logic [XLEN-1:0] dataNext;
	logic [XLEN-1:0] pcNext;
	logic            takenNext;

	assign live    = exValid && !illegal; // illegal has no side effect
	assign pcPlus4 = exPc + XLEN'(4);

	always_comb
	begin
		writeNext = 1'b0;
		dataNext  = aluResult;
		pcNext    = pcPlus4;
		takenNext = 1'b0;
		case (instrClass)
			CLS_ALU:
				writeNext = 1'b1;
			CLS_JAL:
			begin
				writeNext = 1'b1;
				dataNext  = pcPlus4; // link
				pcNext    = aluResult;
			end
			CLS_JALR:
			begin
				writeNext = 1'b1;
				dataNext  = pcPlus4;
				pcNext    = {aluResult[XLEN-1:1], 1'b0};
			end
			CLS_BRANCH:
			begin
				takenNext = aluResult[0]; // compare result is 0 or 1
				if (aluResult[0])
					pcNext = exPc + exImm;
			end
			default:
				writeNext = 1'b0; // load and store
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			resultValid  <= 1'b0;
			illegalInstr <= 1'b0;
			rdWrite      <= 1'b0;
			branchTaken  <= 1'b0;
			memRead      <= 1'b0;
			memWrite     <= 1'b0;
			rdNum        <= '0;
			rdData       <= '0;
			nextPc       <= '0;
			memAddr      <= '0;
			storeData    <= '0;
		end
		else
		begin
			resultValid  <= exValid;
			illegalInstr <= exValid && illegal;
			rdWrite      <= live && writeNext && exRd != 5'd0;
			branchTaken  <= live && takenNext;
			memRead      <= live && instrClass == CLS_LOAD;
			memWrite     <= live && instrClass == CLS_STORE;
			if (exValid)
			begin
				rdNum     <= exRd;
				rdData    <= dataNext;
				nextPc    <= pcNext;
				memAddr   <= aluResult; // rs1 + imm
				storeData <= exStoreData;
			end
		end
	end

	// writeback loop into the register file
	assign wbWrite = rdWrite;
	assign wbNum   = rdNum;
	assign wbData  = rdData;

	memOneStrobe: assert property (@(posedge clk) disable iff (!arstN)
		(memRead || memWrite) |-> resultValid && !(memRead && memWrite));

endmodule

// ==== src/opDecode.sv ====
`timescale 1ns/1ps

module opDecode #(
	parameter int numRegs = 32
) (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          fieldsValid,
	input  logic [6:0]                    opcode,
	input  logic [2:0]                    func3,
	input  logic                          func7Bit5,
	input  logic                          shiftArith,
	input  logic [4:0]                    rs1Num,
	input  logic [4:0]                    rs2Num,
	input  logic [4:0]                    rdNum,
	input  logic [rvExecPkg::XLEN-1:0]    immValue,
	input  logic [rvExecPkg::XLEN-1:0]    pcValue,
	input  logic                          wbWrite,
	input  logic [4:0]                    wbNum,
	input  logic [rvExecPkg::XLEN-1:0]    wbData,
	output logic                          exValid,
	output logic [rvExecPkg::XLEN-1:0]    aluResult,
	output logic [rvExecPkg::CLASS_W-1:0] instrClass,
	output logic [4:0]                    exRd,
	output logic [rvExecPkg::XLEN-1:0]    exPc,
	output logic [rvExecPkg::XLEN-1:0]    exImm,
	output logic [rvExecPkg::XLEN-1:0]    exStoreData,
	output logic                          illegal
);
	import rvExecPkg::*;

	logic [XLEN-1:0]     rs1Data;
	logic [XLEN-1:0]     rs2Data;
	logic [ALU_OP_W-1:0] opNext;
	logic [XLEN-1:0]     xNext;
	logic [XLEN-1:0]     yNext;
	logic [CLASS_W-1:0]  classNext;
	logic                illegalNext;
	logic [ALU_OP_W-1:0] aluOp;
	logic [XLEN-1:0]     aluX;
	logic [XLEN-1:0]     aluY;

	regFile #(
		.numRegs(numRegs)
	) regFile_inst (
		.clk,
		.arstN,
		.readNum0(rs1Num),
		.readNum1(rs2Num),
		.writeEnable(wbWrite),
		.writeNum(wbNum),
		.writeData(wbData),
		.readData0(rs1Data),
		.readData1(rs2Data)
	);

	aluUnit aluUnit_inst (
		.aluOp,
		.aluX,
		.aluY,
		.aluOut(aluResult)
	);

	// default is rs1 + imm, the load / store / jalr case
	always_comb
	begin
		opNext      = ADD;
		xNext       = rs1Data;
		yNext       = immValue;
		classNext   = CLS_ALU;
		illegalNext = 1'b0;
		case (opcode)
			OPC_OP, OPC_OPIMM:
			begin
				if (opcode == OPC_OP)
					yNext = rs2Data;
				case (func3)
					3'd0: opNext = (opcode == OPC_OP && func7Bit5) ? SUB : ADD;
					3'd1: opNext = SLL;
					3'd2: opNext = SLT;
					3'd3: opNext = SLTU;
					3'd4: opNext = XOR;
					3'd5: opNext = shiftArith ? SRA : SRL; // bit 30 in both formats
					3'd6: opNext = OR;
					default: opNext = AND;
				endcase
			end
			OPC_BRANCH:
			begin
				yNext     = rs2Data;
				classNext = CLS_BRANCH;
				case (func3)
					3'd0: opNext = EQ; // beq
					3'd1: opNext = NE; // bne
					3'd4: opNext = SLT; // blt
					3'd5: opNext = GES; // bge
					3'd6: opNext = SLTU; // bltu
					3'd7: opNext = GEU; // bgeu
					default: illegalNext = 1'b1;
				endcase
			end
			OPC_LOAD:
				classNext = CLS_LOAD;
			OPC_STORE:
				classNext = CLS_STORE;
			OPC_JALR:
				classNext = CLS_JALR;
			OPC_JAL:
			begin
				xNext     = pcValue; // target = pc + imm
				classNext = CLS_JAL;
			end
			OPC_AUIPC:
				xNext = pcValue;
			OPC_LUI:
				xNext = '0;
			default:
				illegalNext = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			exValid     <= 1'b0;
			aluOp       <= ADD;
			aluX        <= '0;
			aluY        <= '0;
			instrClass  <= CLS_ALU;
			exRd        <= '0;
			exPc        <= '0;
			exImm       <= '0;
			exStoreData <= '0;
			illegal     <= 1'b0;
		end
		else
		begin
			exValid <= fieldsValid;
			if (fieldsValid)
			begin
				aluOp       <= opNext;
				aluX        <= xNext;
				aluY        <= yNext;
				instrClass  <= classNext;
				exRd        <= rdNum;
				exPc        <= pcValue;
				exImm       <= immValue; // branch offset
				exStoreData <= rs2Data;
				illegal     <= illegalNext;
			end
		end
	end

	exOpDefined: assert property (@(posedge clk) disable iff (!arstN)
		exValid && !illegal |-> aluOp <= GEU);

endmodule

// ==== src/instrFieldSplit.sv ====
`timescale 1ns/1ps

module instrFieldSplit (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic                       instrValid,
	input  rvExecPkg::instrWord        instr,
	input  logic [rvExecPkg::XLEN-1:0] pc,
	output logic                       fieldsValid,
	output logic [6:0]                 opcode,
	output logic [2:0]                 func3,
	output logic                       func7Bit5,
	output logic                       shiftArith,
	output logic [4:0]                 rs1Num,
	output logic [4:0]                 rs2Num,
	output logic [4:0]                 rdNum,
	output logic [rvExecPkg::XLEN-1:0] immValue,
	output logic [rvExecPkg::XLEN-1:0] pcValue
);
	import rvExecPkg::*;

	logic [31:0]     raw;
	logic [XLEN-1:0] immNext;

	assign raw = instr;

	// immediate by format, sign bit is always instr[31]
	always_comb
	begin
		case (instr.rView.opcode)
			OPC_OPIMM, OPC_LOAD, OPC_JALR:
				immNext = {{20{instr.iView.imm12[11]}}, instr.iView.imm12};
			OPC_STORE:
				immNext = {{20{instr.rView.func7[6]}}, instr.rView.func7, instr.rView.rd};
			OPC_BRANCH:
				immNext = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
			OPC_LUI, OPC_AUIPC:
				immNext = {raw[31:12], 12'b0};
			OPC_JAL:
				immNext = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
			default:
				immNext = '0; // R type and unknown opcodes
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			fieldsValid <= 1'b0;
			opcode      <= '0;
			func3       <= '0;
			func7Bit5   <= 1'b0;
			shiftArith  <= 1'b0;
			rs1Num      <= '0;
			rs2Num      <= '0;
			rdNum       <= '0;
			immValue    <= '0;
			pcValue     <= '0;
		end
		else
		begin
			fieldsValid <= instrValid;
			if (instrValid)
			begin
				opcode     <= instr.rView.opcode;
				func3      <= instr.rView.func3;
				func7Bit5  <= instr.rView.func7[5]; // sub / sra select
				shiftArith <= instr.iView.imm12[10]; // srai select
				rs1Num     <= instr.rView.rs1;
				rs2Num     <= instr.rView.rs2;
				rdNum      <= instr.rView.rd;
				immValue   <= immNext;
				pcValue    <= pc;
			end
		end
	end

endmodule

// ==== src/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
	input  logic [rvExecPkg::ALU_OP_W-1:0] aluOp,
	input  logic [rvExecPkg::XLEN-1:0]     aluX,
	input  logic [rvExecPkg::XLEN-1:0]     aluY,
	output logic [rvExecPkg::XLEN-1:0]     aluOut
);
	import rvExecPkg::*;

	logic [4:0] shamt;

	assign shamt = aluY[4:0]; // only low five bits shift

	always_comb
	begin
		case (aluOp)
			ADD:
				aluOut = aluX + aluY;
			SUB:
				aluOut = aluX - aluY;
			SLL:
				aluOut = aluX << shamt;
			SLT:
				aluOut = XLEN'($signed(aluX) < $signed(aluY));
			SLTU:
				aluOut = XLEN'(aluX < aluY);
			XOR:
				aluOut = aluX ^ aluY;
			SRL:
				aluOut = aluX >> shamt;
			SRA:
				aluOut = $signed(aluX) >>> shamt; // sign fill
			OR:
				aluOut = aluX | aluY;
			AND:
				aluOut = aluX & aluY;
			EQ:
				aluOut = XLEN'(aluX == aluY);
			NE:
				aluOut = XLEN'(aluX != aluY);
			GES:
				aluOut = XLEN'($signed(aluX) >= $signed(aluY));
			GEU:
				aluOut = XLEN'(aluX >= aluY);
			default:
				aluOut = '0;
		endcase
	end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile #(
	parameter int numRegs = 32
) (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic [4:0]                 readNum0,
	input  logic [4:0]                 readNum1,
	input  logic                       writeEnable,
	input  logic [4:0]                 writeNum,
	input  logic [rvExecPkg::XLEN-1:0] writeData,
	output logic [rvExecPkg::XLEN-1:0] readData0,
	output logic [rvExecPkg::XLEN-1:0] readData1
);
	import rvExecPkg::*;

	localparam int IDX_W = $clog2(numRegs);

	logic [XLEN-1:0] regs [numRegs];

	// x0 and numbers past the array read as zero
	assign readData0 = (readNum0 != 5'd0 && readNum0 < numRegs) ?
		regs[readNum0[IDX_W-1:0]] : '0;
	assign readData1 = (readNum1 != 5'd0 && readNum1 < numRegs) ?
		regs[readNum1[IDX_W-1:0]] : '0;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			regs <= '{default: '0};
		else if (writeEnable && writeNum != 5'd0 && writeNum < numRegs)
			regs[writeNum[IDX_W-1:0]] <= writeData;
	end

	// writeback number comes from resultStage, must fit this file
	wrNumInRange: assert property (@(posedge clk) disable iff (!arstN)
		writeEnable |-> writeNum < numRegs);

endmodule

// ==== src/rvExecPkg.sv ====
package rvExecPkg;

	localparam int XLEN = 32;

	// major opcodes, instr[6:0]
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

	localparam int ALU_OP_W = 4;

	localparam logic [ALU_OP_W-1:0] ADD  = 4'd0;
	localparam logic [ALU_OP_W-1:0] SUB  = 4'd1;
	localparam logic [ALU_OP_W-1:0] SLL  = 4'd2;
	localparam logic [ALU_OP_W-1:0] SLT  = 4'd3;
	localparam logic [ALU_OP_W-1:0] SLTU = 4'd4;
	localparam logic [ALU_OP_W-1:0] XOR  = 4'd5;
	localparam logic [ALU_OP_W-1:0] SRL  = 4'd6;
	localparam logic [ALU_OP_W-1:0] SRA  = 4'd7;
	localparam logic [ALU_OP_W-1:0] OR   = 4'd8;
	localparam logic [ALU_OP_W-1:0] AND  = 4'd9;
	localparam logic [ALU_OP_W-1:0] EQ   = 4'd10; // branch compares from here on
	localparam logic [ALU_OP_W-1:0] NE   = 4'd11;
	localparam logic [ALU_OP_W-1:0] GES  = 4'd12;
	localparam logic [ALU_OP_W-1:0] GEU  = 4'd13; // highest defined code

	localparam int CLASS_W = 3;

	localparam logic [CLASS_W-1:0] CLS_ALU    = 3'd0;
	localparam logic [CLASS_W-1:0] CLS_LOAD   = 3'd1;
	localparam logic [CLASS_W-1:0] CLS_STORE  = 3'd2;
	localparam logic [CLASS_W-1:0] CLS_BRANCH = 3'd3;
	localparam logic [CLASS_W-1:0] CLS_JAL    = 3'd4;
	localparam logic [CLASS_W-1:0] CLS_JALR   = 3'd5;

	// one instruction word, seen as R or I layout
	typedef union packed {
		struct packed {
			logic [6:0] func7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] func3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} rView;
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  func3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} iView;
	} instrWord;

endpackage
